/* emcPkg.sv */
package emcPkg;

  // External bus widths
  parameter int AddrW = 14;  // PM and DM addresses of the core
  parameter int DataW = 16;
  parameter int WaitW = 3;   // One wait-state field

  // Byte-DMA address parts
  parameter int PageW = 8;
  parameter int BeadW = 12;

  // WSCR is five wait fields side by side
  parameter int WscrW = 5 * WaitW;

  // Field positions in WSCR
  parameter int PmWaitLsb   = 0;
  parameter int DmWaitLsb   = 3;
  parameter int BmWaitLsb   = 6;
  parameter int IoLoWaitLsb = 9;   // I/O below 512
  parameter int IoHiWaitLsb = 12;  // I/O from 512 up

  // Address bit that splits I/O space into its two wait fields
  parameter int IoSplitBit = 9;

  typedef enum logic [1:0] {
    spacePm,
    spaceDm,
    spaceIo,
    spaceBm
  } memSpaceT;

  // One external access: idle, strobe held for wait+1 cycles, then release
  typedef enum logic [1:0] {
    busIdle,
    busStrobe,
    busFinish
  } busStateT;

endpackage

/* waitStateRegs.sv */
`timescale 1ns/1ps

module waitStateRegs
  import emcPkg::*;
#(
  parameter logic [WaitW-1:0] ResetWait = 3'd7
) (
  input  logic             DSPCLK,
  input  logic             rstN,
  input  logic             WSCR_we,
  input  logic [DataW-1:0] DMD,
  input  memSpaceT         selSpace,
  input  logic [AddrW-1:0] selAddr,
  output logic [WscrW-1:0] WSCR,
  output logic [WaitW-1:0] waitCount
);

  logic [WscrW-1:0] wscrQ;

  // Register loads from the data bus, used from the next cycle on
  always_ff @(posedge DSPCLK or negedge rstN) begin
    if (!rstN) begin
      wscrQ <= {5{ResetWait}};
    end else if (WSCR_we) begin
      wscrQ <= DMD[WscrW-1:0];  // Top DMD bit has no field
    end
  end

  assign WSCR = wscrQ;

  // Field for the space the arbiter has chosen this cycle
  always_comb begin
    case (selSpace)
      spacePm: waitCount = wscrQ[PmWaitLsb +: WaitW];
      spaceDm: waitCount = wscrQ[DmWaitLsb +: WaitW];
      spaceBm: waitCount = wscrQ[BmWaitLsb +: WaitW];
      spaceIo: begin
        // Slow peripherals usually sit in the upper half
        if (selAddr[IoSplitBit]) begin
          waitCount = wscrQ[IoHiWaitLsb +: WaitW];
        end else begin
          waitCount = wscrQ[IoLoWaitLsb +: WaitW];
        end
      end
      default: waitCount = wscrQ[PmWaitLsb +: WaitW];
    endcase
  end

endmodule

/* busArbiter.sv */
`timescale 1ns/1ps

module busArbiter
  import emcPkg::*;
(
  input  logic             DSPCLK,
  input  logic             rstN,
  input  logic             accessReq,
  input  memSpaceT         accessSpace,
  input  logic             accessWrite,
  input  logic [AddrW-1:0] accessAddr,
  input  logic [DataW-1:0] accessData,
  input  logic             BSreq,
  input  logic [PageW-1:0] BMpage,
  input  logic [BeadW-1:0] BEAD,
  input  logic             BWRn,
  input  logic [7:0]       BWdataBUF,
  input  logic             busBusy,
  output logic             selReq,
  output memSpaceT         selSpace,
  output logic             selWrite,
  output logic [AddrW-1:0] selAddr,
  output logic [DataW-1:0] selData,
  output logic             selIsDma
);

  logic                   dmaInFlight;  // Current BSreq already served
  logic                   dmaGo;
  logic [PageW+BeadW-1:0] dmaAddrFull;

  // DMA only takes an idle bus that no core strobe wants
  assign dmaGo = BSreq && !busBusy && !dmaInFlight && !accessReq;

  // Page bits sit above the byte offset
  assign dmaAddrFull = {BMpage, BEAD};

  always_ff @(posedge DSPCLK or negedge rstN) begin
    if (!rstN) begin
      dmaInFlight <= 1'b0;
    end else if (dmaGo) begin
      dmaInFlight <= 1'b1;
    end else if (!BSreq) begin
      dmaInFlight <= 1'b0;  // Engine dropped its request after bdmaDone
    end
  end

  assign selReq   = accessReq || dmaGo;
  assign selIsDma = dmaGo;

  always_comb begin
    if (accessReq) begin
      selSpace = accessSpace;
      selWrite = accessWrite;
      selAddr  = accessAddr;
      selData  = accessData;
    end else begin
      selSpace = spaceBm;
      selWrite = !BWRn;
      selAddr  = dmaAddrFull[AddrW-1:0];
      selData  = {{(DataW - 8){1'b0}}, BWdataBUF};  // Byte, zero extended
    end
  end

  // Core must wait for the previous access to wind down
  coreStrobeIdle: assert property (
    @(posedge DSPCLK) disable iff (!rstN) accessReq |-> !busBusy
  ) else $error("Core access strobed while external bus busy");

endmodule

/* extBusSeq.sv */
`timescale 1ns/1ps

module extBusSeq
  import emcPkg::*;
(
  input  logic             DSPCLK,
  input  logic             rstN,
  input  logic             selReq,
  input  memSpaceT         selSpace,
  input  logic             selWrite,
  input  logic [AddrW-1:0] selAddr,
  input  logic [DataW-1:0] selData,
  input  logic             selIsDma,
  input  logic [WaitW-1:0] waitCount,
  input  logic [DataW-1:0] T_ED,
  output logic             busBusy,
  output logic [AddrW-1:0] EA_do,
  output logic             EA_oe,
  output logic [DataW-1:0] ED_do,
  output logic             ED_oe,
  output logic             PMSn,
  output logic             DMSn,
  output logic             IOSn,
  output logic             BMSn,
  output logic             RDn,
  output logic             WRn,
  output logic             eRDY,
  output logic [DataW-1:0] emcDMD_do,
  output logic             emcDMD_oe,
  output logic             bdmaDone
);

  busStateT         state;
  logic [WaitW-1:0] waitCnt;  // Strobe cycles left after this one
  memSpaceT         spaceL;
  logic             writeL;
  logic             isDmaL;
  logic [AddrW-1:0] addrL;
  logic [DataW-1:0] dataL;
  logic [DataW-1:0] rdData;
  logic             startAcc;
  logic             strobing;
  logic             lastStrobe;
  logic             finishing;

  assign startAcc   = (state == busIdle) && selReq;
  assign strobing   = (state == busStrobe);
  assign lastStrobe = strobing && (waitCnt == '0);
  assign finishing  = (state == busFinish);

  always_ff @(posedge DSPCLK or negedge rstN) begin
    if (!rstN) begin
      state   <= busIdle;
      waitCnt <= '0;
      spaceL  <= spacePm;
      writeL  <= 1'b0;
      isDmaL  <= 1'b0;
    end else begin
      case (state)
        busIdle: begin
          if (selReq) begin
            state   <= busStrobe;
            waitCnt <= waitCount;  // Wait field sampled with the request
            spaceL  <= selSpace;
            writeL  <= selWrite;
            isDmaL  <= selIsDma;
          end
        end
        busStrobe: begin
          if (waitCnt == '0) begin
            state <= busFinish;
          end else begin
            waitCnt <= waitCnt - WaitW'(1);
          end
        end
        busFinish: begin
          state <= busIdle;
        end
        default: begin
          state <= busIdle;
        end
      endcase
    end
  end

  // Address and write data held for the whole access
  always_ff @(posedge DSPCLK) begin
    if (startAcc) begin
      addrL <= selAddr;
      dataL <= selData;
    end
  end

  // Read data is taken at the end of the stretched strobe
  always_ff @(posedge DSPCLK) begin
    if (lastStrobe && !writeL) begin
      rdData <= T_ED;
    end
  end

  assign busBusy = (state != busIdle);

  // Pins
  assign EA_do = addrL;
  assign ED_do = dataL;
  assign EA_oe = strobing;
  assign ED_oe = strobing && writeL;

  assign PMSn = !(strobing && spaceL == spacePm);
  assign DMSn = !(strobing && spaceL == spaceDm);
  assign IOSn = !(strobing && spaceL == spaceIo);
  assign BMSn = !(strobing && spaceL == spaceBm);

  assign RDn = !(strobing && !writeL);
  assign WRn = !(strobing && writeL);

  // Core stalls only while the strobe is out
  assign eRDY = !strobing;

  // DMA engine picks up its read byte from emcDMD_do on bdmaDone
  assign emcDMD_do = rdData;
  assign emcDMD_oe = finishing && !isDmaL && !writeL;
  assign bdmaDone  = finishing && isDmaL;

  // Core obeys eRDY from the sequencer
  coreWaitsReady: assert property (
    @(posedge DSPCLK) disable iff (!rstN) (selReq && !selIsDma) |-> eRDY
  ) else $error("Core request while eRDY low");

  oneSelect: assert property (
    @(posedge DSPCLK) disable iff (!rstN) $onehot0(~{PMSn, DMSn, IOSn, BMSn})
  ) else $error("More than one chip select active");

  noRdWrOverlap: assert property (
    @(posedge DSPCLK) disable iff (!rstN) !(!RDn && !WRn)
  ) else $error("RDn and WRn low together");

endmodule

/* emc.sv */
`timescale 1ns/1ps

module emc
  import emcPkg::*;
#(
  parameter logic [WaitW-1:0] ResetWait = 3'd7  // Slowest setting out of reset
) (
  input  logic             DSPCLK,
  input  logic             rstN,
  // Core access
  input  logic             accessReq,
  input  memSpaceT         accessSpace,
  input  logic             accessWrite,
  input  logic [AddrW-1:0] accessAddr,
  input  logic [DataW-1:0] accessData,
  // Wait register
  input  logic             WSCR_we,
  input  logic [DataW-1:0] DMD,
  // Byte DMA
  input  logic             BSreq,
  input  logic [PageW-1:0] BMpage,
  input  logic [BeadW-1:0] BEAD,
  input  logic             BWRn,
  input  logic [7:0]       BWdataBUF,
  // External bus
  input  logic [DataW-1:0] T_ED,
  output logic             PMSn,
  output logic             DMSn,
  output logic             IOSn,
  output logic             BMSn,
  output logic             RDn,
  output logic             WRn,
  output logic [AddrW-1:0] EA_do,
  output logic             EA_oe,
  output logic [DataW-1:0] ED_do,
  output logic             ED_oe,
  // Back to core and DMA
  output logic             eRDY,
  output logic [DataW-1:0] emcDMD_do,
  output logic             emcDMD_oe,
  output logic             bdmaDone,
  output logic [WscrW-1:0] WSCR
);

  logic             selReq;
  memSpaceT         selSpace;
  logic             selWrite;
  logic [AddrW-1:0] selAddr;
  logic [DataW-1:0] selData;
  logic             selIsDma;
  logic [WaitW-1:0] waitCount;
  logic             busBusy;

  waitStateRegs #(
    .ResetWait(ResetWait)
  ) waitStateRegs_inst (
    .DSPCLK   (DSPCLK),
    .rstN     (rstN),
    .WSCR_we  (WSCR_we),
    .DMD      (DMD),
    .selSpace (selSpace),
    .selAddr  (selAddr),
    .WSCR     (WSCR),
    .waitCount(waitCount)
  );

  busArbiter busArbiter_inst (
    .DSPCLK     (DSPCLK),
    .rstN       (rstN),
    .accessReq  (accessReq),
    .accessSpace(accessSpace),
    .accessWrite(accessWrite),
    .accessAddr (accessAddr),
    .accessData (accessData),
    .BSreq      (BSreq),
    .BMpage     (BMpage),
    .BEAD       (BEAD),
    .BWRn       (BWRn),
    .BWdataBUF  (BWdataBUF),
    .busBusy    (busBusy),
    .selReq     (selReq),
    .selSpace   (selSpace),
    .selWrite   (selWrite),
    .selAddr    (selAddr),
    .selData    (selData),
    .selIsDma   (selIsDma)
  );

  extBusSeq extBusSeq_inst (
    .DSPCLK   (DSPCLK),
    .rstN     (rstN),
    .selReq   (selReq),
    .selSpace (selSpace),
    .selWrite (selWrite),
    .selAddr  (selAddr),
    .selData  (selData),
    .selIsDma (selIsDma),
    .waitCount(waitCount),
    .T_ED     (T_ED),
    .busBusy  (busBusy),
    .EA_do    (EA_do),
    .EA_oe    (EA_oe),
    .ED_do    (ED_do),
    .ED_oe    (ED_oe),
    .PMSn     (PMSn),
    .DMSn     (DMSn),
    .IOSn     (IOSn),
    .BMSn     (BMSn),
    .RDn      (RDn),
    .WRn      (WRn),
    .eRDY     (eRDY),
    .emcDMD_do(emcDMD_do),
    .emcDMD_oe(emcDMD_oe),
    .bdmaDone (bdmaDone)
  );

endmodule

/* emcTb.sv */
`timescale 1ns/1ps

module emcTb
  import emcPkg::*;
;

  logic             DSPCLK;
  logic             rstN;
  logic             accessReq;
  memSpaceT         accessSpace;
  logic             accessWrite;
  logic [AddrW-1:0] accessAddr;
  logic [DataW-1:0] accessData;
  logic             WSCR_we;
  logic [DataW-1:0] DMD;
  logic             BSreq;
  logic [PageW-1:0] BMpage;
  logic [BeadW-1:0] BEAD;
  logic             BWRn;
  logic [7:0]       BWdataBUF;
  logic [DataW-1:0] T_ED;
  logic             PMSn, DMSn, IOSn, BMSn, RDn, WRn;
  logic [AddrW-1:0] EA_do;
  logic             EA_oe;
  logic [DataW-1:0] ED_do;
  logic             ED_oe;
  logic             eRDY;
  logic [DataW-1:0] emcDMD_do;
  logic             emcDMD_oe;
  logic             bdmaDone;
  logic [WscrW-1:0] WSCR;

  // Stimulus table
  int          nLines;
  logic        loaded;
  int          opQ[64];
  int          spaceQ[64];
  logic [19:0] addrQ[64];
  logic [15:0] dataQ[64];
  int          waitQ[64];
  logic [15:0] rdQ[64];

  logic [AddrW-1:0] wrAddr;  // Last write seen by the memory model
  logic [DataW-1:0] wrData;
  logic [WscrW-1:0] wscrModel;

  emc #(.ResetWait(3'd7)) emc_inst (.*);

  always #5 DSPCLK = ~DSPCLK;

  // External memory: reads return a pattern of the address
  assign T_ED = {2'b00, EA_do} ^ 16'h5a3c;

  always @(posedge DSPCLK) begin
    if (!WRn) begin
      wrAddr <= EA_do;
      wrData <= ED_do;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "Check on %s failed", name);
    end
  endtask

  // Follows one access on the pins, from strobe start to the finish cycle
  task automatic watchAccess(input logic [1:0] sp, input logic [13:0] ad, input logic wr,
                             input logic [15:0] wd, input int waitExp, input logic dma,
                             input logic [15:0] rdExp);
    int         strobes;
    logic       done;
    logic [3:0] selExp;  // PMSn, DMSn, IOSn, BMSn
    strobes = 0;
    done = 1'b0;
    selExp = ~(4'b1000 >> sp);
    while (!done) begin
      @(negedge DSPCLK);
      if (!RDn || !WRn) begin
        strobes++;
        checkEq("chip selects", 32'({PMSn, DMSn, IOSn, BMSn}), 32'(selExp));
        checkEq("EA_do", 32'(EA_do), 32'(ad));
        checkEq("EA_oe", 32'(EA_oe), 32'd1);
        checkEq("eRDY", 32'(eRDY), 32'd0);
        checkEq("RDn", 32'(RDn), 32'(wr));
        checkEq("WRn", 32'(WRn), 32'(!wr));
        checkEq("ED_oe", 32'(ED_oe), 32'(wr));
        if (wr) checkEq("ED_do", 32'(ED_do), 32'(wd));
      end else if (strobes > 0) begin
        done = 1'b1;  // Finish cycle
      end
    end
    checkEq("strobe cycles", 32'(strobes), 32'(waitExp + 1));
    checkEq("eRDY", 32'(eRDY), 32'd1);
    checkEq("bdmaDone", 32'(bdmaDone), 32'(dma));
    checkEq("emcDMD_oe", 32'(emcDMD_oe), 32'(!dma && !wr));
    if (!wr) begin
      checkEq("emcDMD_do", 32'(emcDMD_do), 32'(rdExp));
    end else begin
      checkEq("write address", 32'(wrAddr), 32'(ad));
      checkEq("write data", 32'(wrData), 32'(wd));
    end
  endtask

  task automatic loadStimulus();
    int    fd;
    int    n;
    string line;
    int    op, sp, wt;
    logic [19:0] ad;
    logic [15:0] wd, rd;
    fd = $fopen("emcStimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      $display("*** TEST FAILED ***");
      $fatal(1, "No stimulus");
    end
    nLines = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 3 && line[0] != "#") begin
        n = $sscanf(line, "%d %d %h %h %d %h", op, sp, ad, wd, wt, rd);
        if (n == 6) begin
          opQ[nLines] = op;
          spaceQ[nLines] = sp;
          addrQ[nLines] = ad;
          dataQ[nLines] = wd;
          waitQ[nLines] = wt;
          rdQ[nLines] = rd;
          nLines++;
        end
      end
    end
    $fclose(fd);
    if (nLines == 0) begin
      $display("No access lines found in the stimulus file");
      $display("*** TEST FAILED ***");
      $fatal(1, "Empty stimulus");
    end
  endtask

  // Watchdog sized from the stimulus length
  initial begin
    wait (loaded);
    repeat (nLines * 64 + 16 + 8) @(posedge DSPCLK);
    $display("Timed out waiting for the external bus to finish");
    $display("*** TEST FAILED ***");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    logic [31:0] rng;
    logic [19:0] dAddr;
    int          bmWait;
    DSPCLK = 1'b0;
    rstN = 1'b0;
    accessReq = 1'b0;
    accessSpace = spacePm;
    accessWrite = 1'b0;
    accessAddr = '0;
    accessData = '0;
    WSCR_we = 1'b0;
    DMD = '0;
    BSreq = 1'b0;
    BMpage = '0;
    BEAD = '0;
    BWRn = 1'b1;
    BWdataBUF = '0;
    loaded = 1'b0;
    rng = 32'h7d09;
    wscrModel = {5{3'd7}};
    loadStimulus();
    loaded = 1'b1;
    repeat (16) @(posedge DSPCLK);
    rstN <= 1'b1;
    @(negedge DSPCLK);
    checkEq("selects after reset", 32'({PMSn, DMSn, IOSn, BMSn, RDn, WRn}), 32'h3f);
    checkEq("enables after reset", 32'({EA_oe, ED_oe, emcDMD_oe, bdmaDone}), 32'h0);
    checkEq("eRDY after reset", 32'(eRDY), 32'd1);
    checkEq("WSCR after reset", 32'(WSCR), 32'(wscrModel));
    for (int i = 0; i < nLines; i++) begin
      rng = xorshift(rng);
      repeat (rng[1:0]) @(posedge DSPCLK);  // Idle gap
      dAddr = addrQ[i];
      @(posedge DSPCLK);
      case (opQ[i])
        0: begin
          WSCR_we <= 1'b1;
          DMD <= dataQ[i];
          @(posedge DSPCLK);
          WSCR_we <= 1'b0;
          wscrModel = dataQ[i][WscrW-1:0];
          @(negedge DSPCLK);
          checkEq("WSCR", 32'(WSCR), 32'(wscrModel));
        end
        1, 2, 5: begin
          accessReq <= 1'b1;
          accessSpace <= memSpaceT'(spaceQ[i][1:0]);
          accessWrite <= (opQ[i] == 2);
          accessAddr <= dAddr[13:0];
          accessData <= dataQ[i];
          if (opQ[i] == 5) begin
            BSreq <= 1'b1;  // Same cycle as the core strobe
            BMpage <= dAddr[19:12];
            BEAD <= dAddr[11:0];
            BWRn <= 1'b1;
          end
          @(posedge DSPCLK);
          accessReq <= 1'b0;
          watchAccess(spaceQ[i][1:0], dAddr[13:0], opQ[i] == 2, dataQ[i], waitQ[i],
                      1'b0, rdQ[i]);
          if (opQ[i] == 5) begin
            bmWait = int'(wscrModel[8:6]);
            watchAccess(2'd3, dAddr[13:0], 1'b0, 16'h0, bmWait, 1'b1,
                        {2'b00, dAddr[13:0]} ^ 16'h5a3c);
            @(posedge DSPCLK);
            BSreq <= 1'b0;
          end
        end
        3, 4: begin
          BSreq <= 1'b1;
          BMpage <= dAddr[19:12];
          BEAD <= dAddr[11:0];
          BWRn <= (opQ[i] != 4);
          BWdataBUF <= dataQ[i][7:0];
          watchAccess(2'd3, dAddr[13:0], opQ[i] == 4, {8'h00, dataQ[i][7:0]}, waitQ[i],
                      1'b1, rdQ[i]);
          @(posedge DSPCLK);
          BSreq <= 1'b0;  // Engine drops request after bdmaDone
        end
        default: begin
          $display("Unknown operation code in stimulus line %0d", i);
          $display("*** TEST FAILED ***");
          $fatal(1, "Bad stimulus line");
        end
      endcase
    end
    repeat (4) @(posedge DSPCLK);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* emcStimulus.txt */
# op space addr wdata wait expected_rdata (hex for addr, wdata, rdata)
# op 0 WSCR write, 1 core read, 2 core write, 3 DMA read, 4 DMA write, 5 core read with DMA read
1 0 0123 0000 7 5b1f
1 1 0456 0000 7 5e6a
1 2 0010 0000 7 5a2c
1 2 0210 0000 7 582c
1 3 0aaa 0000 7 5096
0 0 0000 50d1 0 0000
1 0 1234 0000 1 4808
1 1 2001 0000 2 7a3d
1 2 0100 0000 0 5b3c
1 2 0300 0000 5 593c
1 3 3fff 0000 3 65c3
2 0 0040 beef 1 0000
2 1 0041 1234 2 0000
2 2 0005 00ff 0 0000
2 2 0205 abcd 5 0000
2 3 0777 cafe 3 0000
3 3 12345 0000 3 7979
4 3 0a0ff 0055 3 0000
5 1 0033 0000 2 5a0f
0 0 0000 0000 0 0000
1 0 0001 0000 0 5a3d
2 1 0002 5555 0 0000
3 3 00010 0000 0 5a2c
4 3 fffff 00a5 0 0000
5 0 0100 0000 0 5b3c
1 2 03ff 0000 0 59c3
0 0 0000 2e4a 0 0000
1 0 0fff 0000 2 55c3
1 2 01ff 0000 7 5bc3
1 2 0200 0000 2 583c
2 1 3000 0f0f 1 0000
3 3 00abc 0000 1 5080
5 1 1000 0000 1 4a3c
0 0 0000 7fff 0 0000
1 1 0456 0000 7 5e6a
2 2 0300 1111 7 0000

/* verilog.f */
emcPkg.sv
waitStateRegs.sv
busArbiter.sv
extBusSeq.sv
emc.sv
emcTb.sv

/* run.sh */
#!/bin/sh
# Build and run the emc testbench with Verilator
verilator --binary --timing --assert -f verilog.f --top-module emcTb -o emcSim \
  && ./obj_dir/emcSim \
  || { echo "Simulation run failed"; exit 1; }
